// ==== source/satd_pkg.sv ====
// Block geometry, data widths and derived sizes for the SATD cost engine
`default_nettype none

package satd_pkg;

    // ----------------------------------------------------------
    // Block geometry
    // ----------------------------------------------------------

    // Side length of a transform block
    localparam int BLOCK_DIM = 4;

    // Pixels in, coefficients out
    localparam int NUM_COEF = BLOCK_DIM * BLOCK_DIM;

    // ----------------------------------------------------------
    // Data widths
    // ----------------------------------------------------------

    // Unsigned pixel or residual byte
    localparam int PIX_W = 8;

    // One row of pixels, pixel 0 in the low byte
    localparam int ROW_W = BLOCK_DIM * PIX_W;

    // Signed per-coefficient weight
    localparam int WEIGHT_W = 16;

    // Transform coefficient magnitude, max 16 * 255
    localparam int COEF_W = 13;

    // Weighted cost, compared as signed
    localparam int COST_W = 32;

    // Candidate number, wraps at 256
    localparam int INDEX_W = 8;

    // Weight bank address
    localparam int WADDR_W = 4;

    // Loader row counter
    localparam int ROW_IDX_W = 2;

endpackage : satd_pkg

`default_nettype wire

// ==== source/weight_regs.sv ====
// Host-writable bank of sixteen signed coefficient weights
`timescale 1ns/100ps
`default_nettype none

module weight_regs
    import satd_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,

    // Host write port
    input  logic                         w_wr_i,
    input  logic [WADDR_W-1:0]           w_addr_i,
    input  logic signed [WEIGHT_W-1:0]   w_data_i,

    // All weights, coefficient 0 in the low word
    output logic [NUM_COEF*WEIGHT_W-1:0] weights_o
);

    logic signed [WEIGHT_W-1:0] weight_q [NUM_COEF];

    // ----------------------------------------------------------
    // Weight storage
    // ----------------------------------------------------------

    // Unit weights give plain SATD out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_COEF; i++) begin
                weight_q[i] <= WEIGHT_W'(1);
            end
        end else if (w_wr_i) begin
            weight_q[w_addr_i] <= w_data_i;
        end
    end

    // ----------------------------------------------------------
    // Flatten for the cost pipeline
    // ----------------------------------------------------------

    for (genvar i = 0; i < NUM_COEF; i++) begin : g_flat
        assign weights_o[i*WEIGHT_W +: WEIGHT_W] = weight_q[i];
    end

endmodule : weight_regs

`default_nettype wire

// ==== source/block_loader.sv ====
// Row gatherer that assembles 4x4 pixel blocks and pulses a start per block
`timescale 1ns/100ps
`default_nettype none

module block_loader
    import satd_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,

    // Incoming pixel rows, top row first
    input  logic                      row_valid_i,
    input  logic [ROW_W-1:0]          row_data_i,

    // Assembled block to the cost pipeline
    output logic [NUM_COEF*PIX_W-1:0] block_o,
    output logic                      start_o
);

    logic [ROW_IDX_W-1:0] row_cnt_q;
    logic [ROW_W-1:0]     row_q [BLOCK_DIM];
    logic                 last_row;
    logic                 start_q;

    // Bottom row of the block is being written
    assign last_row = (row_cnt_q == ROW_IDX_W'(BLOCK_DIM - 1));

    // ----------------------------------------------------------
    // Row counter and start pulse
    // ----------------------------------------------------------

    // Counter wraps on its own after the last row
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_cnt_q <= '0;
            start_q   <= 1'b0;
        end else begin
            start_q <= row_valid_i & last_row;
            if (row_valid_i) begin
                row_cnt_q <= row_cnt_q + 1'b1;
            end
        end
    end

    // ----------------------------------------------------------
    // Block register
    // ----------------------------------------------------------

    // A row of the next block may arrive on the edge where the
    // pipeline samples this one, it still sees the old contents
    always_ff @(posedge clk) begin
        if (row_valid_i) begin
            row_q[row_cnt_q] <= row_data_i;
        end
    end

    for (genvar r = 0; r < BLOCK_DIM; r++) begin : g_block
        assign block_o[r*ROW_W +: ROW_W] = row_q[r];
    end

    assign start_o = start_q;

endmodule : block_loader

`default_nettype wire

// ==== source/hadamard_cost.sv ====
// Three-stage pipeline computing the weighted 4x4 Hadamard cost of a block
`timescale 1ns/100ps
`default_nettype none

module hadamard_cost
    import satd_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,

    // Block in, sampled on start
    input  logic                         start_i,
    input  logic [NUM_COEF*PIX_W-1:0]    block_i,
    input  logic [NUM_COEF*WEIGHT_W-1:0] weights_i,

    // Cost out, valid with done
    output logic [COST_W-1:0]            cost_o,
    output logic                         done_o
);

    // Row pass grows two bits over the pixel, column pass two more
    logic signed [COEF_W-3:0]   pix    [NUM_COEF];
    logic signed [COEF_W-3:0]   row_t  [NUM_COEF];
    logic signed [COEF_W-1:0]   col_t  [NUM_COEF];
    logic        [COEF_W-1:0]   mag_q  [NUM_COEF];
    logic signed [WEIGHT_W-1:0] weight [NUM_COEF];
    logic signed [COST_W-1:0]   prod   [NUM_COEF];
    logic signed [COST_W-1:0]   pair_q [NUM_COEF/2];
    logic signed [COST_W-1:0]   total;
    logic        [2:0]          vld_q;

    // Unpack pixels as non-negative signed values, and the weights
    for (genvar i = 0; i < NUM_COEF; i++) begin : g_unpack
        assign pix[i]    = {{(COEF_W-2-PIX_W){1'b0}}, block_i[i*PIX_W +: PIX_W]};
        assign weight[i] = weights_i[i*WEIGHT_W +: WEIGHT_W];
    end

    // ----------------------------------------------------------
    // Stage 1 transform and magnitude
    // ----------------------------------------------------------

    // Horizontal butterflies, one per row
    for (genvar r = 0; r < BLOCK_DIM; r++) begin : g_row
        logic signed [COEF_W-3:0] s0, s1, d0, d1;

        assign s0 = pix[BLOCK_DIM*r + 0] + pix[BLOCK_DIM*r + 2];
        assign s1 = pix[BLOCK_DIM*r + 1] + pix[BLOCK_DIM*r + 3];
        assign d1 = pix[BLOCK_DIM*r + 1] - pix[BLOCK_DIM*r + 3];
        assign d0 = pix[BLOCK_DIM*r + 0] - pix[BLOCK_DIM*r + 2];

        assign row_t[BLOCK_DIM*r + 0] = s0 + s1;
        assign row_t[BLOCK_DIM*r + 1] = d0 + d1;
        assign row_t[BLOCK_DIM*r + 2] = d0 - d1;
        assign row_t[BLOCK_DIM*r + 3] = s0 - s1;
    end

    // Vertical butterflies on the row results
    for (genvar c = 0; c < BLOCK_DIM; c++) begin : g_col
        logic signed [COEF_W-1:0] s0, s1, d0, d1;

        assign s0 = row_t[c]               + row_t[c + 2*BLOCK_DIM];
        assign s1 = row_t[c + BLOCK_DIM]   - (-row_t[c + 3*BLOCK_DIM]);
        assign d1 = row_t[c + BLOCK_DIM]   - row_t[c + 3*BLOCK_DIM];
        assign d0 = row_t[c]               - row_t[c + 2*BLOCK_DIM];

        assign col_t[c]               = s0 + s1;
        assign col_t[c + BLOCK_DIM]   = d0 + d1;
        assign col_t[c + 2*BLOCK_DIM] = d0 - d1;
        assign col_t[c + 3*BLOCK_DIM] = s0 - s1;
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            for (int i = 0; i < NUM_COEF; i++) begin
                mag_q[i] <= col_t[i][COEF_W-1] ? -col_t[i] : col_t[i];
            end
        end
    end

    // ----------------------------------------------------------
    // Stage 2 weighting and pair sums
    // ----------------------------------------------------------

    // Magnitude is zero extended so the product takes the weight's sign
    for (genvar i = 0; i < NUM_COEF; i++) begin : g_mul
        assign prod[i] = $signed({1'b0, mag_q[i]}) * weight[i];
    end

    always_ff @(posedge clk) begin
        if (vld_q[0]) begin
            for (int k = 0; k < NUM_COEF/2; k++) begin
                pair_q[k] <= prod[2*k] + prod[2*k + 1];
            end
        end
    end

    // ----------------------------------------------------------
    // Stage 3 total
    // ----------------------------------------------------------

    always_comb begin
        total = '0;
        for (int k = 0; k < NUM_COEF/2; k++) begin
            total = total + pair_q[k];
        end
    end

    always_ff @(posedge clk) begin
        if (vld_q[1]) begin
            cost_o <= total;
        end
    end

    // One valid bit per stage, a new block may enter every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[1:0], start_i};
        end
    end

    assign done_o = vld_q[2];

endmodule : hadamard_cost

`default_nettype wire

// ==== source/cost_tracker.sv ====
// Candidate numbering and running minimum of the block costs
`timescale 1ns/100ps
`default_nettype none

module cost_tracker
    import satd_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               clear_i,

    // Finished block from the cost pipeline
    input  logic               done_i,
    input  logic [COST_W-1:0]  cost_i,

    // Per-block result
    output logic [COST_W-1:0]  cost_o,
    output logic               cost_valid_o,
    output logic [INDEX_W-1:0] cand_index_o,

    // Best candidate since the last clear
    output logic [COST_W-1:0]  best_cost_o,
    output logic [INDEX_W-1:0] best_index_o
);

    logic [INDEX_W-1:0] cand_cnt_q;
    logic [INDEX_W-1:0] idx_now;
    logic               best_vld_q;
    logic               take_best;

    // A clear in the same cycle makes this block candidate 0
    assign idx_now = clear_i ? '0 : cand_cnt_q;

    // Empty tracker takes any cost, ties keep the earlier one
    assign take_best = clear_i || !best_vld_q ||
                       ($signed(cost_i) < $signed(best_cost_o));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cost_o       <= '0;
            cost_valid_o <= 1'b0;
            cand_index_o <= '0;
            cand_cnt_q   <= '0;
            best_cost_o  <= '1;
            best_index_o <= '0;
            best_vld_q   <= 1'b0;
        end else begin
            cost_valid_o <= done_i;

            if (clear_i) begin
                cand_cnt_q   <= '0;
                best_cost_o  <= '1;
                best_index_o <= '0;
                best_vld_q   <= 1'b0;
            end

            // Later assignments override the clear above
            if (done_i) begin
                cost_o       <= cost_i;
                cand_index_o <= idx_now;
                cand_cnt_q   <= idx_now + 1'b1;
                if (take_best) begin
                    best_cost_o  <= cost_i;
                    best_index_o <= idx_now;
                    best_vld_q   <= 1'b1;
                end
            end
        end
    end

endmodule : cost_tracker

`default_nettype wire

// ==== source/satd_engine_top.sv ====
// Top level of the weighted SATD cost engine
`timescale 1ns/100ps
`default_nettype none

module satd_engine_top
    import satd_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,

    // Pixel rows
    input  logic                       row_valid_i,
    input  logic [ROW_W-1:0]           row_data_i,

    // Weight writes
    input  logic                       w_wr_i,
    input  logic [WADDR_W-1:0]         w_addr_i,
    input  logic signed [WEIGHT_W-1:0] w_data_i,

    // Tracker control and results
    input  logic                       clear_i,
    output logic [COST_W-1:0]          cost_o,
    output logic                       cost_valid_o,
    output logic [INDEX_W-1:0]         cand_index_o,
    output logic [COST_W-1:0]          best_cost_o,
    output logic [INDEX_W-1:0]         best_index_o
);

    logic [NUM_COEF*PIX_W-1:0]    block;
    logic                         start;
    logic [NUM_COEF*WEIGHT_W-1:0] weights;
    logic [COST_W-1:0]            pipe_cost;
    logic                         pipe_done;

    // ----------------------------------------------------------
    // Front end
    // ----------------------------------------------------------

    block_loader u_block_loader (
        .clk         (clk),
        .rst_n       (rst_n),
        .row_valid_i (row_valid_i),
        .row_data_i  (row_data_i),
        .block_o     (block),
        .start_o     (start)
    );

    weight_regs u_weight_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .w_wr_i    (w_wr_i),
        .w_addr_i  (w_addr_i),
        .w_data_i  (w_data_i),
        .weights_o (weights)
    );

    // ----------------------------------------------------------
    // Cost pipeline and tracker
    // ----------------------------------------------------------

    hadamard_cost u_hadamard_cost (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (start),
        .block_i   (block),
        .weights_i (weights),
        .cost_o    (pipe_cost),
        .done_o    (pipe_done)
    );

    cost_tracker u_cost_tracker (
        .clk          (clk),
        .rst_n        (rst_n),
        .clear_i      (clear_i),
        .done_i       (pipe_done),
        .cost_i       (pipe_cost),
        .cost_o       (cost_o),
        .cost_valid_o (cost_valid_o),
        .cand_index_o (cand_index_o),
        .best_cost_o  (best_cost_o),
        .best_index_o (best_index_o)
    );

endmodule : satd_engine_top

`default_nettype wire

// ==== bench/satd_engine_tb.sv ====
// Testbench for the SATD cost engine with a reference cost model and compare tasks
`timescale 1ns/100ps
`default_nettype none

module satd_engine_tb
    import satd_pkg::*;
;

    logic                       clk;
    logic                       rst_n;
    logic                       row_valid_i;
    logic [ROW_W-1:0]           row_data_i;
    logic                       w_wr_i;
    logic [WADDR_W-1:0]         w_addr_i;
    logic signed [WEIGHT_W-1:0] w_data_i;
    logic                       clear_i;
    logic [COST_W-1:0]          cost_o;
    logic                       cost_valid_o;
    logic [INDEX_W-1:0]         cand_index_o;
    logic [COST_W-1:0]          best_cost_o;
    logic [INDEX_W-1:0]         best_index_o;

    // Model state
    logic [PIX_W-1:0]           blk [NUM_COEF];
    logic signed [WEIGHT_W-1:0] wmodel [NUM_COEF];
    logic [COST_W-1:0]          exp_cost_q [$];
    int                         exp_cycle_q [$];
    logic [COST_W-1:0]          m_best_cost;
    logic [INDEX_W-1:0]         m_best_index;
    logic [INDEX_W-1:0]         m_cand;
    logic                       m_best_vld;
    int                         cyc;
    string                      test_name;

    satd_engine_top UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .row_valid_i  (row_valid_i),
        .row_data_i   (row_data_i),
        .w_wr_i       (w_wr_i),
        .w_addr_i     (w_addr_i),
        .w_data_i     (w_data_i),
        .clear_i      (clear_i),
        .cost_o       (cost_o),
        .cost_valid_o (cost_valid_o),
        .cand_index_o (cand_index_o),
        .best_cost_o  (best_cost_o),
        .best_index_o (best_index_o)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // ------------------------------------------------------------
    // Compare tasks and reference model
    // ------------------------------------------------------------

    task automatic check_cost(input string what, input logic [COST_W-1:0] exp_v,
                              input logic [COST_W-1:0] act_v);
        if (exp_v !== act_v) begin
            $display("[ERROR] %s %s expected %0d actual %0d", test_name, what,
                     $signed(exp_v), $signed(act_v));
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic check_index(input string what, input logic [INDEX_W-1:0] exp_v,
                               input logic [INDEX_W-1:0] act_v);
        if (exp_v !== act_v) begin
            $display("[ERROR] %s %s expected %0d actual %0d", test_name, what, exp_v, act_v);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    // Hadamard basis row u, entry i
    function automatic int hsign(input int u, input int i);
        case (u)
            0: return 1;
            1: return (i < 2) ? 1 : -1;
            2: return (i == 0 || i == 3) ? 1 : -1;
            default: return (i == 0 || i == 2) ? 1 : -1;
        endcase
    endfunction

    function automatic logic [COST_W-1:0] model_cost();
        int coef;
        int sum;
        sum = 0;
        for (int u = 0; u < BLOCK_DIM; u++) begin
            for (int v = 0; v < BLOCK_DIM; v++) begin
                coef = 0;
                for (int i = 0; i < BLOCK_DIM; i++) begin
                    for (int j = 0; j < BLOCK_DIM; j++) begin
                        coef += hsign(u, i) * hsign(v, j) * int'(blk[BLOCK_DIM*i + j]);
                    end
                end
                if (coef < 0) coef = -coef;
                sum += coef * int'(wmodel[BLOCK_DIM*u + v]);
            end
        end
        return COST_W'(sum);
    endfunction

    // Result monitor, sampled on the falling edge
    always @(negedge clk) begin
        logic [COST_W-1:0] exp_c;
        int                exp_t;
        if (rst_n && cost_valid_o) begin
            if (exp_cost_q.size() == 0) begin
                $display("%s: cost_valid_o pulsed with no block outstanding", test_name);
                $display("Finished with errors");
                $fatal(1);
            end
            exp_c = exp_cost_q.pop_front();
            exp_t = exp_cycle_q.pop_front();
            if (exp_t != cyc) begin
                $display("[ERROR] %s latency expected cycle %0d actual %0d",
                         test_name, exp_t, cyc);
                $display("Finished with errors");
                $fatal(1);
            end
            check_cost("cost_o", exp_c, cost_o);
            check_index("cand_index_o", m_cand, cand_index_o);
            if (!m_best_vld || $signed(exp_c) < $signed(m_best_cost)) begin
                m_best_cost  = exp_c;
                m_best_index = m_cand;
                m_best_vld   = 1'b1;
            end
            m_cand = m_cand + 1'b1;
            check_cost("best_cost_o", m_best_cost, best_cost_o);
            check_index("best_index_o", m_best_index, best_index_o);
        end
    end

    // ------------------------------------------------------------
    // Stimulus tasks
    // ------------------------------------------------------------

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic random_block();
        for (int i = 0; i < NUM_COEF; i++) begin
            blk[i] = PIX_W'($urandom);
        end
    endtask

    // Last row leaves row_valid_i high so blocks can run back to back
    task automatic send_block();
        for (int r = 0; r < BLOCK_DIM; r++) begin
            tick();
            row_valid_i = 1'b1;
            row_data_i  = {blk[4*r+3], blk[4*r+2], blk[4*r+1], blk[4*r]};
        end
        exp_cost_q.push_back(model_cost());
        exp_cycle_q.push_back(cyc + 5);
    endtask

    task automatic idle_rows();
        tick();
        row_valid_i = 1'b0;
    endtask

    task automatic write_weight(input int addr, input logic signed [WEIGHT_W-1:0] data);
        tick();
        w_wr_i   = 1'b1;
        w_addr_i = WADDR_W'(addr);
        w_data_i = data;
        wmodel[addr] = data;
    endtask

    task automatic end_writes();
        tick();
        w_wr_i = 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (exp_cost_q.size() != 0) begin
            if (n == 50) begin
                $display("%s: cost_valid_o never came for an outstanding block", test_name);
                $display("Finished with errors");
                $fatal(1);
            end
            @(posedge clk);
            n++;
        end
        tick();
    endtask

    task automatic pulse_clear();
        tick();
        clear_i = 1'b1;
        tick();
        clear_i      = 1'b0;
        m_best_cost  = '1;
        m_best_index = '0;
        m_cand       = '0;
        m_best_vld   = 1'b0;
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------

    initial begin
        logic [INDEX_W-1:0] first_zero;
        void'($urandom(32'h824b));
        clk = 1'b0;
        rst_n = 1'b0;
        row_valid_i = 1'b0;
        row_data_i = '0;
        w_wr_i = 1'b0;
        w_addr_i = '0;
        w_data_i = '0;
        clear_i = 1'b0;
        cyc = 0;
        test_name = "reset";
        for (int i = 0; i < NUM_COEF; i++) wmodel[i] = 16'sd1;
        m_best_cost = '1;
        m_best_index = '0;
        m_cand = '0;
        m_best_vld = 1'b0;
        repeat (4) @(posedge clk);
        #2 rst_n = 1'b1;

        test_name = "default_weights";
        for (int b = 0; b < 8; b++) begin
            random_block();
            send_block();
            idle_rows();
        end
        wait_idle();

        test_name = "random_weights";
        for (int i = 0; i < NUM_COEF; i++) begin
            write_weight(i, WEIGHT_W'($urandom));
        end
        write_weight(3, -16'sd77);
        end_writes();
        for (int b = 0; b < 8; b++) begin
            random_block();
            send_block();
            idle_rows();
        end
        wait_idle();

        test_name = "back_to_back";
        for (int b = 0; b < 12; b++) begin
            random_block();
            send_block();
        end
        idle_rows();
        wait_idle();

        test_name = "best_tracking";
        for (int i = 0; i < NUM_COEF; i++) write_weight(i, 16'sd1);
        end_writes();
        // Negative costs from the weighted tests would hide the zero block
        pulse_clear();
        random_block();
        send_block();
        first_zero = m_cand + 1'b1;
        for (int i = 0; i < NUM_COEF; i++) blk[i] = '0;
        send_block();
        send_block();
        random_block();
        send_block();
        idle_rows();
        wait_idle();
        check_index("tie keeps earlier index", first_zero, best_index_o);
        check_cost("zero block best cost", '0, best_cost_o);

        test_name = "clear";
        pulse_clear();
        check_cost("best_cost_o after clear", '1, best_cost_o);
        random_block();
        send_block();
        idle_rows();
        wait_idle();
        check_index("first index after clear", '0, cand_index_o);
        check_index("best index after clear", '0, best_index_o);
        check_cost("best cost after clear", model_cost(), best_cost_o);

        $display("Finished with no errors");
        $finish;
    end

endmodule : satd_engine_tb

`default_nettype wire

// ==== satd_engine_top.f ====
source/satd_pkg.sv
source/weight_regs.sv
source/block_loader.sv
source/hadamard_cost.sv
source/cost_tracker.sv
source/satd_engine_top.sv
bench/satd_engine_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SATD engine testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f satd_engine_top.f --top-module satd_engine_tb \
    -o satd_sim > sim.log 2>&1 \
    && ./obj_dir/satd_sim >> sim.log 2>&1 \
    || echo "simulation build or run returned an error" >> sim.log
cat sim.log
grep -q "Finished with errors" sim.log && exit 1
grep -q "Finished with no errors" sim.log || exit 1
exit 0
